// ==== verilog/streamer_pkg.sv ====
// Streamer shared types
`default_nettype none

package streamer_pkg;

  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned LEN_W  = 16;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;       // Byte address
  typedef logic [ADDR_W-3:0] word_addr_t;  // Byte address without the offset bits
  typedef logic [LEN_W-1:0]  len_t;

  // Job descriptor, strides in bytes
  typedef struct packed {
    addr_t base_addr;
    addr_t d0_stride;
    len_t  d0_len;     // Words per row
    addr_t d1_stride;  // Row start to row start
    len_t  tot_len;
  } ag_ctrl_t;

  typedef struct packed {
    logic done;
  } ag_flags_t;

  typedef struct packed {
    logic     req_start;
    ag_ctrl_t ag_ctrl;
  } src_ctrl_t;

  typedef struct packed {
    logic      ready_start;
    logic      done;
    ag_flags_t ag_flags;
  } src_flags_t;

  typedef struct packed {
    logic empty;
    logic full;
  } fifo_flags_t;

  // TCDM master side, wen high means read
  typedef struct packed {
    logic       req;
    addr_t      add;
    logic       wen;
    logic [3:0] be;
    data_t      data;
    logic       lrdy;
  } tcdm_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_data;
  } tcdm_rsp_t;

  typedef struct packed {
    logic  valid;
    data_t data;
  } stream_t;

  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_WORKING,
    SRC_DONE
  } src_state_t;

endpackage

`default_nettype wire

// ==== verilog/stream_addr_gen.sv ====
// Two-dimensional address generator
`timescale 1ns/1ps
`default_nettype none

module stream_addr_gen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     enable_i,
  input  logic                     presample_i,
  input  streamer_pkg::ag_ctrl_t   ctrl_i,
  output streamer_pkg::word_addr_t addr_o,
  output logic                     addr_valid_o,
  input  logic                     addr_ready_i,
  output streamer_pkg::ag_flags_t  flags_o
);

  streamer_pkg::ag_ctrl_t ctrl_q;     // Descriptor of the running job
  streamer_pkg::addr_t    addr_q;     // Current byte address
  streamer_pkg::addr_t    row_q;      // Start of the current row
  streamer_pkg::len_t     d0_cnt_q;   // Position inside the row
  streamer_pkg::len_t     tot_cnt_q;  // Words pushed so far
  streamer_pkg::addr_t    next_row;
  logic                   active_q;
  logic                   done_q;
  logic                   push;
  logic                   last_in_row;
  logic                   last_word;

  assign push        = addr_valid_o & addr_ready_i;
  assign last_in_row = (d0_cnt_q == ctrl_q.d0_len - 1'b1);
  assign last_word   = (tot_cnt_q == ctrl_q.tot_len - 1'b1);
  assign next_row    = row_q + ctrl_q.d1_stride;

  assign addr_valid_o = enable_i & active_q;
  assign addr_o       = addr_q[streamer_pkg::ADDR_W-1:2];
  assign flags_o      = '{done: done_q};

  always_ff @(posedge clk_i) begin
    if (presample_i) begin
      ctrl_q <= ctrl_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q    <= '0;
      row_q     <= '0;
      d0_cnt_q  <= '0;
      tot_cnt_q <= '0;
      active_q  <= 1'b0;
      done_q    <= 1'b0;
    end else if (clear_i) begin
      addr_q    <= '0;
      row_q     <= '0;
      d0_cnt_q  <= '0;
      tot_cnt_q <= '0;
      active_q  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= push & last_word;  // One cycle after the last push
      if (presample_i) begin
        addr_q    <= ctrl_i.base_addr;
        row_q     <= ctrl_i.base_addr;
        d0_cnt_q  <= '0;
        tot_cnt_q <= '0;
        active_q  <= 1'b1;
      end else if (push) begin
        tot_cnt_q <= tot_cnt_q + 1'b1;
        if (last_word) begin
          active_q <= 1'b0;
        end
        // Wrap to the next row start
        if (last_in_row) begin
          d0_cnt_q <= '0;
          row_q    <= next_row;
          addr_q   <= next_row;
        end else begin
          d0_cnt_q <= d0_cnt_q + 1'b1;
          addr_q   <= addr_q + ctrl_q.d0_stride;
        end
      end
    end
  end

  // Word addresses only, offset bits are dropped on the way out
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    presample_i |-> (ctrl_i.base_addr[1:0] == 2'b00))
    else $error("Unaligned base address on presample");

endmodule

`default_nettype wire

// ==== verilog/addr_fifo.sv ====
// Word address FIFO
`timescale 1ns/1ps
`default_nettype none

module addr_fifo (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  streamer_pkg::word_addr_t  push_data_i,
  input  logic                      push_valid_i,
  output logic                      push_ready_o,
  output streamer_pkg::word_addr_t  pop_data_o,
  output logic                      pop_valid_o,
  input  logic                      pop_ready_i,
  output streamer_pkg::fifo_flags_t flags_o
);

  streamer_pkg::word_addr_t mem_q [2];
  logic                     wr_ptr_q;
  logic                     rd_ptr_q;
  logic [1:0]               cnt_q;     // Occupancy, 0 to 2
  logic                     empty;
  logic                     full;
  logic                     push;
  logic                     pop;

  assign empty = (cnt_q == 2'd0);
  assign full  = (cnt_q == 2'd2);
  assign push  = push_valid_i & push_ready_o;
  assign pop   = pop_valid_o & pop_ready_i;

  assign push_ready_o = ~full;
  assign pop_valid_o  = ~empty;
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign flags_o      = '{empty: empty, full: full};

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else if (clear_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      wr_ptr_q <= wr_ptr_q ^ push;
      rd_ptr_q <= rd_ptr_q ^ pop;
      cnt_q    <= cnt_q + {1'b0, push} - {1'b0, pop};
    end
  end

  // A push held off by a full FIFO stays pending rather than vanishing
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (push_valid_i && full && !pop_ready_i) |=> push_valid_i)
    else $error("Push dropped while FIFO full");

  // Consumer only pops what is there
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_ready_i |-> !empty)
    else $error("Pop from empty FIFO");

endmodule

`default_nettype wire

// ==== verilog/stream_source.sv ====
// TCDM to stream source
`timescale 1ns/1ps
`default_nettype none

module stream_source (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  streamer_pkg::src_ctrl_t  ctrl_i,
  output streamer_pkg::src_flags_t flags_o,
  output streamer_pkg::tcdm_req_t  tcdm_req_o,
  input  streamer_pkg::tcdm_rsp_t  tcdm_rsp_i,
  output streamer_pkg::stream_t    stream_o,
  input  logic                     stream_ready_i
);

  streamer_pkg::src_state_t  cs, ns;
  streamer_pkg::ag_flags_t   ag_flags;
  streamer_pkg::fifo_flags_t fifo_flags;
  streamer_pkg::word_addr_t  ag_addr;
  streamer_pkg::word_addr_t  fifo_addr;
  streamer_pkg::data_t       skid_data_q;
  streamer_pkg::data_t       out_data;
  streamer_pkg::len_t        cnt_q;
  logic                      ag_valid;
  logic                      ag_ready;
  logic                      fifo_valid;
  logic                      fifo_ready;
  logic                      ag_en;
  logic                      ag_clr;
  logic                      presample;
  logic                      ready_start;
  logic                      job_done;
  logic                      req;
  logic                      skid_valid_q;
  logic                      out_valid;

  assign presample = ctrl_i.req_start & (cs == streamer_pkg::SRC_IDLE);
  assign ag_en     = (cs != streamer_pkg::SRC_IDLE);
  assign ag_clr    = clear_i | job_done;

  stream_addr_gen i_addr_gen (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( ag_clr         ),
    .enable_i     ( ag_en          ),
    .presample_i  ( presample      ),
    .ctrl_i       ( ctrl_i.ag_ctrl ),
    .addr_o       ( ag_addr        ),
    .addr_valid_o ( ag_valid       ),
    .addr_ready_i ( ag_ready       ),
    .flags_o      ( ag_flags       )
  );

  addr_fifo i_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_data_i  ( ag_addr    ),
    .push_valid_i ( ag_valid   ),
    .push_ready_o ( ag_ready   ),
    .pop_data_o   ( fifo_addr  ),
    .pop_valid_o  ( fifo_valid ),
    .pop_ready_i  ( fifo_ready ),
    .flags_o      ( fifo_flags )
  );

  // No new request while the stream is stalled or a clear is pending
  assign req        = ag_en & fifo_valid & stream_ready_i & ~clear_i;
  assign fifo_ready = req & tcdm_rsp_i.gnt;

  assign tcdm_req_o = '{req: req, add: {fifo_addr, 2'b00}, wen: 1'b1, be: 4'hF,
                        data: '0, lrdy: stream_ready_i};

  // Response bypasses the skid register when it is empty
  assign out_valid = tcdm_rsp_i.r_valid | skid_valid_q;
  assign out_data  = tcdm_rsp_i.r_valid ? tcdm_rsp_i.r_data : skid_data_q;
  assign stream_o  = '{valid: out_valid, data: out_data};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      skid_valid_q <= 1'b0;
    end else if (clear_i) begin
      skid_valid_q <= 1'b0;
    end else if (tcdm_rsp_i.r_valid) begin
      skid_valid_q <= ~stream_ready_i;  // Hold the word until ready
    end else if (stream_ready_i) begin
      skid_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tcdm_rsp_i.r_valid) begin
      skid_data_q <= tcdm_rsp_i.r_data;
    end
  end

  // Delivered words
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i || job_done) begin
      cnt_q <= '0;
    end else if (out_valid && stream_ready_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs <= streamer_pkg::SRC_IDLE;
    end else if (clear_i) begin
      cs <= streamer_pkg::SRC_IDLE;
    end else begin
      cs <= ns;
    end
  end

  always_comb begin
    ns          = cs;
    ready_start = 1'b0;
    job_done    = 1'b0;
    case (cs)
      streamer_pkg::SRC_IDLE: begin
        ready_start = 1'b1;
        if (ctrl_i.req_start) begin
          ns = streamer_pkg::SRC_WORKING;
        end
      end
      streamer_pkg::SRC_WORKING: begin
        if (ag_flags.done) begin
          ns = streamer_pkg::SRC_DONE;  // All addresses pushed
        end
      end
      streamer_pkg::SRC_DONE: begin
        // Wait for the last word to leave on the stream
        if (fifo_flags.empty && (cnt_q == ctrl_i.ag_ctrl.tot_len)) begin
          ns       = streamer_pkg::SRC_IDLE;
          job_done = 1'b1;
        end
      end
      default: ns = streamer_pkg::SRC_IDLE;
    endcase
  end

  assign flags_o = '{ready_start: ready_start, done: job_done, ag_flags: ag_flags};

  // Memory answers only what was granted one cycle before
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    tcdm_rsp_i.r_valid |-> $past(tcdm_req_o.req && tcdm_rsp_i.gnt))
    else $error("Read response without grant");

  // Stalled stream word is held
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid && !stream_ready_i && !clear_i) |=> (out_valid && $stable(out_data)))
    else $error("Stream word changed under back-pressure");

endmodule

`default_nettype wire

// ==== verilog/stream_source_top.sv ====
// Stream source subsystem
`timescale 1ns/1ps
`default_nettype none

module stream_source_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,

  // Register file side
  input  streamer_pkg::src_ctrl_t  ctrl_i,
  output streamer_pkg::src_flags_t flags_o,

  // Interconnect side
  output streamer_pkg::tcdm_req_t  tcdm_req_o,
  input  streamer_pkg::tcdm_rsp_t  tcdm_rsp_i,

  // Output stream
  output streamer_pkg::stream_t    stream_o,
  input  logic                     stream_ready_i
);

  stream_source i_source (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .ctrl_i         ( ctrl_i         ),
    .flags_o        ( flags_o        ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .tcdm_rsp_i     ( tcdm_rsp_i     ),
    .stream_o       ( stream_o       ),
    .stream_ready_i ( stream_ready_i )
  );

endmodule

`default_nettype wire

// ==== verif/tcdm_mem_model.sv ====
// TCDM memory model
`timescale 1ns/1ps
`default_nettype none

module tcdm_mem_model (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    rand_gnt_i,
  input  streamer_pkg::tcdm_req_t tcdm_req_i,
  output streamer_pkg::tcdm_rsp_t tcdm_rsp_o
);

  streamer_pkg::data_t mem_q [16];  // Preloaded by the testbench
  streamer_pkg::data_t r_data_q;
  logic                r_valid_q;
  logic                coin_q;
  logic                gnt;

  assign gnt        = tcdm_req_i.req & (~rand_gnt_i | coin_q);
  assign tcdm_rsp_o = '{gnt: gnt, r_valid: r_valid_q, r_data: r_data_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      r_data_q  <= '0;
      coin_q    <= 1'b1;
    end else begin
      coin_q    <= 1'($urandom % 2);  // Grant coin for the next cycle
      r_valid_q <= gnt;
      if (gnt) begin
        r_data_q <= mem_q[tcdm_req_i.add[5:2]];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_stream_source.sv ====
// Stream source testbench
`timescale 1ns/1ps
`default_nettype none

module tb_stream_source;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     clear_i;
  logic                     stream_ready;
  logic                     rand_gnt;
  streamer_pkg::src_ctrl_t  ctrl;
  streamer_pkg::src_flags_t flags;
  streamer_pkg::tcdm_req_t  tcdm_req;
  streamer_pkg::tcdm_rsp_t  tcdm_rsp;
  streamer_pkg::stream_t    strm;
  streamer_pkg::ag_ctrl_t   job_desc;  // Descriptor of the job being driven

  logic [31:0]         vec [0:255];
  streamer_pkg::data_t exp_q [$];
  int ptr;
  int got;
  int done_cnt;
  int ag_done_cnt;
  int data_errs;
  int flag_errs;
  int other_errs;

  stream_source_top dut (
    .clk_i, .rst_ni, .clear_i,
    .ctrl_i(ctrl), .flags_o(flags),
    .tcdm_req_o(tcdm_req), .tcdm_rsp_i(tcdm_rsp),
    .stream_o(strm), .stream_ready_i(stream_ready)
  );

  tcdm_mem_model mem (
    .clk_i, .rst_ni, .rand_gnt_i(rand_gnt), .tcdm_req_i(tcdm_req), .tcdm_rsp_o(tcdm_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_word(input streamer_pkg::data_t act, input streamer_pkg::data_t exp);
    if (act !== exp) begin
      data_errs++;
      $display("[ERROR] %0t ns: word %0d is %h, expected %h", $time, got, act, exp);
    end
  endtask

  task automatic check_flags(input streamer_pkg::src_flags_t act,
                             input streamer_pkg::src_flags_t exp, input string what);
    if (act !== exp) begin
      flag_errs++;
      $display("[ERROR] %0t ns: flags %b after %s, expected %b", $time, act, what, exp);
    end
  endtask

  // Inputs change on the falling edge and outputs settle before the rising one
  task automatic step_cycle(input logic [3:0] mode, input logic start, input logic clr);
    @(negedge clk_i);
    ctrl.req_start = start;
    ctrl.ag_ctrl   = job_desc;
    clear_i        = clr;
    stream_ready   = mode[0] ? 1'($urandom % 2) : 1'b1;
    rand_gnt       = mode[1];
    #1;
    if (tcdm_req.req && !stream_ready) begin
      other_errs++;
      $display("[ERROR] %0t ns: request issued while the stream is stalled", $time);
    end
    if (tcdm_req.lrdy !== stream_ready || tcdm_req.wen !== 1'b1 || tcdm_req.be !== 4'hF) begin
      other_errs++;
      $display("[ERROR] %0t ns: lrdy %b wen %b be %h, expected lrdy %b wen 1 be f",
               $time, tcdm_req.lrdy, tcdm_req.wen, tcdm_req.be, stream_ready);
    end
    if (strm.valid && stream_ready) begin
      if (got < exp_q.size()) begin
        check_word(strm.data, exp_q[got]);
      end else begin
        other_errs++;
        $display("Extra stream word %h at %0t ns", strm.data, $time);
      end
      got++;
    end
    if (flags.done) done_cnt++;
    if (flags.ag_flags.done) ag_done_cnt++;
  endtask

  task automatic run_job();
    logic [3:0] mode;
    int tot;
    int timeout;
    mode = vec[ptr][3:0];
    job_desc = '{base_addr: vec[ptr+1], d0_stride: vec[ptr+2], d0_len: vec[ptr+3][15:0],
                 d1_stride: vec[ptr+4], tot_len: vec[ptr+5][15:0]};
    tot = vec[ptr+5];
    ptr += 6;
    exp_q.delete();
    for (int i = 0; i < tot; i++) exp_q.push_back(vec[ptr+i]);
    ptr += tot;
    got = 0;
    done_cnt = 0;
    ag_done_cnt = 0;
    step_cycle(mode, 1'b1, 1'b0);
    timeout = 0;
    while (done_cnt == 0 && timeout < 2000) begin
      step_cycle(mode, 1'b0, 1'b0);
      timeout++;
      if (mode[2] && got >= 3) begin
        step_cycle(mode, 1'b0, 1'b1);
        step_cycle(mode, 1'b0, 1'b0);
        check_flags(flags, '{ready_start: 1'b1, done: 1'b0, ag_flags: 1'b0}, "clear");
        if (strm.valid) begin
          other_errs++;
          $display("[ERROR] %0t ns: stream valid still high one cycle after clear", $time);
        end
        return;
      end
    end
    if (done_cnt == 0) begin
      $display("Timeout waiting for done of a job");
      $display("Finished with errors");
      $finish;
    end
    // Idle again right after the done pulse
    step_cycle(mode, 1'b0, 1'b0);
    check_flags(flags, '{ready_start: 1'b1, done: 1'b0, ag_flags: 1'b0}, "job end");
    repeat (3) step_cycle(mode, 1'b0, 1'b0);
    if (got != tot || done_cnt != 1 || ag_done_cnt != 1) begin
      other_errs++;
      $display("[ERROR] %0t ns: %0d of %0d words, %0d done, %0d address done pulses",
               $time, got, tot, done_cnt, ag_done_cnt);
    end
  endtask

  initial begin
    int n;
    void'($urandom(32'h9275414d));
    rst_ni = 1'b0;
    clear_i = 1'b0;
    stream_ready = 1'b1;
    rand_gnt = 1'b0;
    ctrl = '0;
    job_desc = '0;
    data_errs = 0;
    flag_errs = 0;
    other_errs = 0;
    $readmemh("verif/stream_input.txt", vec);
    n = vec[0];
    for (int i = 0; i < n; i++) mem.mem_q[i] = vec[1+i];
    ptr = n + 1;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flags(flags, '{ready_start: 1'b1, done: 1'b0, ag_flags: 1'b0}, "reset");
    if (strm.valid || tcdm_req.req) begin
      other_errs++;
      $display("[ERROR] %0t ns: stream valid %b and TCDM req %b after reset, expected 0 and 0",
               $time, strm.valid, tcdm_req.req);
    end
    n = vec[ptr];
    ptr++;
    for (int j = 0; j < n; j++) run_job();
    $display("Errors: %0d data, %0d flags, %0d other", data_errs, flag_errs, other_errs);
    if (data_errs + flag_errs + other_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/streamer_pkg.sv
verilog/stream_addr_gen.sv
verilog/addr_fifo.sv
verilog/stream_source.sv
verilog/stream_source_top.sv
verif/tcdm_mem_model.sv
verif/tb_stream_source.sv

// ==== Bender.yml ====
package:
  name: stream_source

sources:
  - verilog/streamer_pkg.sv
  - verilog/stream_addr_gen.sv
  - verilog/addr_fifo.sv
  - verilog/stream_source.sv
  - verilog/stream_source_top.sv
  - target: test
    files:
      - verif/tcdm_mem_model.sv
      - verif/tb_stream_source.sv

// ==== verif/stream_input.txt ====
// Line 1: memory word count, then memory words from byte address 0
// Jobs: count, then mode base d0_stride d0_len d1_stride tot_len and tot_len expected words
00000010
d0000000 d1010001 d2020002 d3030003 d4040004 d5050005 d6060006 d7070007
d8080008 d9090009 da0a000a db0b000b dc0c000c dd0d000d de0e000e df0f000f
00000006
// Mode bit 0 random ready, bit 1 random grant, bit 2 clear mid-job
0 00000000 00000004 0004 00000010 0004
d0000000 d1010001 d2020002 d3030003
0 00000004 00000004 0002 00000010 0006
d1010001 d2020002 d5050005 d6060006 d9090009 da0a000a
1 00000004 00000004 0002 00000010 0006
d1010001 d2020002 d5050005 d6060006 d9090009 da0a000a
2 00000020 00000008 0003 00000018 0003
d8080008 da0a000a dc0c000c
4 00000000 00000004 0008 00000020 0008
d0000000 d1010001 d2020002 d3030003 d4040004 d5050005 d6060006 d7070007
3 00000000 00000004 0005 00000014 0005
d0000000 d1010001 d2020002 d3030003 d4040004
